// File: retro_v.f
+incdir+src
src/rv_pkg.sv
src/rv_control.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_core.sv
test/tb_clock.sv
test/tb_core.sv

// File: run_sim.sh
#!/bin/sh
# Build the rv32i core testbench with Verilator and run it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_core -f retro_v.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_core
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation returned status $status"
  exit "$status"
fi

exit 0

// File: test/core_trace.txt
# P addr word : program or data word, preloaded little-endian
# S addr byte : expected bus write, in order
P 000 00001537
P 004 80050593
P 008 F9C00093
P 00C 00700113
P 010 002081B3
P 014 0035A023
P 018 40110233
P 01C 0045A223
P 020 0020C2B3
P 024 0055A423
P 028 0020E333
P 02C 0020F3B3
P 030 0065A623
P 034 0075A823
P 038 00209433
P 03C 0085AA23
P 040 0020D4B3
P 044 0095AC23
P 048 4020D633
P 04C 00C5AE23
P 050 0020A6B3
P 054 0020B733
P 058 02D58023
P 05C 02E580A3
P 060 FFF14793
P 064 03016813
P 068 0F00F893
P 06C 01C11913
P 070 01C0D993
P 074 4040DA13
P 078 F9D0AA93
P 07C FFF13B13
P 080 02F5A223
P 084 0305A423
P 088 0315A623
P 08C 0325A823
P 090 0335AA23
P 094 0345AC23
P 098 03558E23
P 09C 03658EA3
P 0A0 00208463
P 0A4 001B8B93
P 0A8 00210463
P 0AC 00000023
P 0B0 00211463
P 0B4 001B8B93
P 0B8 00209463
P 0BC 00000023
P 0C0 00114463
P 0C4 001B8B93
P 0C8 0020C463
P 0CC 00000023
P 0D0 0020D463
P 0D4 001B8B93
P 0D8 00115463
P 0DC 00000023
P 0E0 0020E463
P 0E4 001B8B93
P 0E8 00116463
P 0EC 00000023
P 0F0 00117463
P 0F4 001B8B93
P 0F8 0020F463
P 0FC 00000023
P 100 03758F23
P 104 00800C6F
P 108 00000023
P 10C 0585A023
P 110 12100C93
P 114 000C8D67
P 118 00000023
P 11C 00000023
P 120 05A5A223
P 124 10058D93
P 128 000D8E03
P 12C 05C5A423
P 130 001DCE03
P 134 05C5A623
P 138 002D9E03
P 13C 05C5A823
P 140 000DDE03
P 144 05C5AA23
P 148 000DAE03
P 14C 05C5AC23
P 150 05C59E23
P 154 FE250E23
P 158 0000006F
P 900 F0A79685
S 800 A3
S 801 FF
S 802 FF
S 803 FF
S 804 6B
S 805 00
S 806 00
S 807 00
S 808 9B
S 809 FF
S 80A FF
S 80B FF
S 80C 9F
S 80D FF
S 80E FF
S 80F FF
S 810 04
S 811 00
S 812 00
S 813 00
S 814 00
S 815 CE
S 816 FF
S 817 FF
S 818 FF
S 819 FF
S 81A FF
S 81B 01
S 81C FF
S 81D FF
S 81E FF
S 81F FF
S 820 01
S 821 00
S 824 F8
S 825 FF
S 826 FF
S 827 FF
S 828 37
S 829 00
S 82A 00
S 82B 00
S 82C 90
S 82D 00
S 82E 00
S 82F 00
S 830 00
S 831 00
S 832 00
S 833 70
S 834 0F
S 835 00
S 836 00
S 837 00
S 838 F9
S 839 FF
S 83A FF
S 83B FF
S 83C 01
S 83D 01
S 83E 06
S 840 08
S 841 01
S 842 00
S 843 00
S 844 18
S 845 01
S 846 00
S 847 00
S 848 85
S 849 FF
S 84A FF
S 84B FF
S 84C 96
S 84D 00
S 84E 00
S 84F 00
S 850 A7
S 851 F0
S 852 FF
S 853 FF
S 854 85
S 855 96
S 856 00
S 857 00
S 858 85
S 859 96
S 85A A7
S 85B F0
S 85C 85
S 85D 96
S FFC 07

// File: test/tb_core.sv
//**************************************************************************
// rv32i core testbench with byte memory model and trace-driven write checks
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_params.svh"

module tb_core;

  localparam logic [15:0] DONE_ADDR = 16'h0FFC;
  localparam int          MAX_WR    = 256;

  logic                  clk;
  logic                  arst_n;
  logic                  hold;
  logic [7:0]            data_in;
  logic [`RV_ADDR_W-1:0] address;
  logic [7:0]            data_out;
  logic                  wren;

  logic [7:0]  mem [4096];               // 4 KB byte memory
  logic [15:0] exp_addr [MAX_WR];
  logic [7:0]  exp_data [MAX_WR];
  int          s_count;
  int          p_count;
  int          s_idx;
  int          cycle_count;
  int          timeout_limit;
  logic [31:0] rng_state;
  logic        done_seen;

  tb_clock u_clock (.clk, .arst_n);

  rv_core DUT (
    .clk, .arst_n, .hold, .data_in, .address, .data_out, .wren
  );

  assign data_in = mem[address[11:0]];  // combinational read

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on a failed check");
  endtask

  task automatic load_trace();
    int          fd;
    string       line;
    byte         kind;
    logic [31:0] a;
    logic [31:0] v;
    fd = $fopen("test/core_trace.txt", "r");
    assert (fd != 0) else stop_with_failure("could not open test/core_trace.txt");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 3 || line[0] == "#") begin
        continue;                        // header or blank line
      end
      void'($sscanf(line, "%c %h %h", kind, a, v));
      if (kind == "P") begin
        for (int k = 0; k < 4; k++) begin
          mem[12'(a + 32'(k))] = v[8*k +: 8];  // little-endian
        end
        p_count++;
      end else if (kind == "S") begin
        assert (s_count < MAX_WR) else stop_with_failure("too many expected writes in trace");
        exp_addr[s_count] = a[15:0];
        exp_data[s_count] = v[7:0];
        s_count++;
      end
    end
    $fclose(fd);
  endtask

  // compare one bus write with the next expected trace line
  task automatic check_write();
    assert (s_idx < s_count)
      else stop_with_failure($sformatf("unexpected extra write to %h after the last one",
                                       address));
    assert (address == exp_addr[s_idx] && data_out == exp_data[s_idx])
      else stop_with_failure($sformatf("ERROR %0t: write %0d got %h <= %h, expected %h <= %h",
                                       $time, s_idx, address, data_out,
                                       exp_addr[s_idx], exp_data[s_idx]));
    mem[address[11:0]] = data_out;
    s_idx++;
    if (address == DONE_ADDR) begin
      done_seen = 1'b1;
    end
  endtask

  initial begin
    hold          = 1'b0;
    s_count       = 0;
    p_count       = 0;
    s_idx         = 0;
    timeout_limit = 0;
    done_seen     = 1'b0;
    rng_state     = 32'd90376;
    for (int i = 0; i < 4096; i++) begin
      mem[i] = 8'(i ^ (i >> 4));         // fill tied to full address
    end
    load_trace();
    timeout_limit = 200 * (p_count + s_count);

    wait (arst_n === 1'b1);
    #1;
    assert (address == `RV_ADDR_W'(`RV_START_ADDR) && !wren)
      else stop_with_failure($sformatf("ERROR %0t: after reset address %h wren %b",
                                       $time, address, wren));

    while (!done_seen) begin
      @(negedge clk);
      rng_state = xorshift32(rng_state);
      hold      = (rng_state[1:0] == 2'b00);  // stall about 1 in 4
      #1;                                // sample once outputs have settled
      if (wren && !hold) begin
        check_write();
      end
    end

    if (s_idx == s_count) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      stop_with_failure($sformatf("done write arrived after only %0d of %0d writes",
                                  s_idx, s_count));
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit != 0) begin
      assert (cycle_count < timeout_limit)
        else stop_with_failure($sformatf("timeout: no done write after %0d cycles",
                                         cycle_count));
    end
  end

  initial cycle_count = 0;

endmodule

`default_nettype wire

// File: test/tb_clock.sv
//**************************************************************************
// testbench clock (20 ns period) and reset held low for 10 cycles
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;                       // released on a falling edge
  end

endmodule

`default_nettype wire

// File: src/rv_core.sv
//**************************************************************************
// rv32i core top, sequencer and datapath on a byte-wide memory bus
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_params.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  hold,
  input  logic [7:0]            data_in,
  output logic [`RV_ADDR_W-1:0] address,
  output logic [7:0]            data_out,
  output logic                  wren
);
  import rv_pkg::*;

  dec_t       dec;
  word_t      imm, pc, rs1, rs2;
  word_t      alu_result, target, eff_addr, load_data, wb_data;
  logic       fetch_en, inst_ready, branch_taken;
  logic       lsu_start, mem_busy, wb_en;
  logic [1:0] fetch_byte, wb_sel;

  // writeback source
  assign wb_data = (wb_sel == `RV_WB_LOAD) ? load_data  :
                   (wb_sel == `RV_WB_LINK) ? pc + 32'd4 : alu_result;

  rv_control u_control (
    .clk, .arst_n, .hold, .inst_ready, .dec, .branch_taken,
    .target, .eff_addr, .mem_busy, .fetch_en, .fetch_byte,
    .lsu_start, .wb_en, .wb_sel, .pc, .address
  );

  rv_decode u_decode (
    .clk, .arst_n, .hold, .fetch_en, .fetch_byte, .data_in,
    .dec, .imm, .inst_ready
  );

  rv_regfile u_regfile (
    .clk, .arst_n,
    .rs1_idx (dec.rs1), .rs2_idx (dec.rs2), .wr_idx (dec.rd),
    .wr_en   (wb_en),   .wr_data (wb_data),
    .rs1, .rs2
  );

  rv_alu u_alu (
    .dec, .rs1, .rs2, .imm, .pc,
    .result (alu_result), .target, .eff_addr, .branch_taken
  );

  rv_lsu u_lsu (
    .clk, .arst_n, .hold, .start (lsu_start), .dec, .store_data (rs2),
    .data_in, .mem_busy, .byte_idx (), .load_data, .data_out, .wren
  );

endmodule

`default_nettype wire

// File: src/rv_lsu.sv
//**************************************************************************
// load/store unit, moves one byte per cycle over the 8-bit bus
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          hold,
  input  logic          start,
  input  rv_pkg::dec_t  dec,
  input  rv_pkg::word_t store_data,
  input  logic [7:0]    data_in,
  output logic          mem_busy,
  output logic [1:0]    byte_idx,
  output rv_pkg::word_t load_data,
  output logic [7:0]    data_out,
  output logic          wren
);
  import rv_pkg::*;

  logic       active;
  logic [1:0] last_idx;
  logic       is_store;
  word_t      buf_q;                     // bytes gathered so far
  word_t      merged;

  always_comb begin
    case (dec.mem_size)
      MEM_BYTE: last_idx = 2'd0;
      MEM_HALF: last_idx = 2'd1;
      default:  last_idx = 2'd3;
    endcase
  end

  assign is_store = (dec.op_class == CLS_STORE);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active   <= 1'b0;
      byte_idx <= 2'd0;
    end else if (!hold) begin
      if (start) begin
        active   <= 1'b1;
        byte_idx <= 2'd0;
      end else if (active) begin
        if (byte_idx == last_idx) begin
          active   <= 1'b0;
          byte_idx <= 2'd0;
        end else begin
          byte_idx <= byte_idx + 2'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && !hold) begin
      buf_q[{byte_idx, 3'b000} +: 8] <= data_in;
    end
  end

  // last byte comes straight from the bus so writeback can close the cycle
  always_comb begin
    merged = buf_q;
    merged[{byte_idx, 3'b000} +: 8] = data_in;
    case (dec.mem_size)
      MEM_BYTE: load_data = {{24{merged[7] & ~dec.load_unsigned}}, merged[7:0]};
      MEM_HALF: load_data = {{16{merged[15] & ~dec.load_unsigned}}, merged[15:0]};
      default:  load_data = merged;
    endcase
  end

  assign mem_busy = active && (byte_idx != last_idx);
  assign wren     = active && is_store;
  assign data_out = store_data[{byte_idx, 3'b000} +: 8];  // little-endian

endmodule

`default_nettype wire

// File: src/rv_alu.sv
//**************************************************************************
// execute unit: alu result, branch compare, jump target, load/store address
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module rv_alu (
  input  rv_pkg::dec_t  dec,
  input  rv_pkg::word_t rs1,
  input  rv_pkg::word_t rs2,
  input  rv_pkg::word_t imm,
  input  rv_pkg::word_t pc,
  output rv_pkg::word_t result,
  output rv_pkg::word_t target,
  output rv_pkg::word_t eff_addr,
  output logic          branch_taken
);
  import rv_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      addr_sum;
  logic [4:0] shamt;
  logic       cond;

  assign op_a  = dec.use_pc ? pc : rs1;
  assign op_b  = dec.use_imm ? imm : rs2;
  assign shamt = op_b[4:0];              // shift amount only 5 bits

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = word_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   result = word_t'(op_a < op_b);
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $signed(op_a) >>> shamt;
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;         // lui
      default:    result = '0;
    endcase
  end

  // branch compares always use the two registers
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = (rs1 == rs2);
      3'b001:  cond = (rs1 != rs2);
      3'b100:  cond = ($signed(rs1) < $signed(rs2));
      3'b101:  cond = ($signed(rs1) >= $signed(rs2));
      3'b110:  cond = (rs1 < rs2);
      3'b111:  cond = (rs1 >= rs2);
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = (dec.op_class == CLS_BRANCH) && cond;

  assign addr_sum = rs1 + imm;
  assign eff_addr = addr_sum;
  assign target   = (dec.op_class == CLS_JALR) ? {addr_sum[31:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

// File: src/rv_regfile.sv
//**************************************************************************
// register file, 2 async read ports and 1 write port, x0 reads zero
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_params.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             arst_n,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::reg_idx_t wr_idx,
  input  logic             wr_en,
  input  rv_pkg::word_t    wr_data,
  output rv_pkg::word_t    rs1,
  output rv_pkg::word_t    rs2
);
  import rv_pkg::*;

  word_t regs [`RV_NREGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rs1 = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2 = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

// File: src/rv_decode.sv
//**************************************************************************
// instruction decoder: byte assembly, field extraction, immediates
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_params.svh"

module rv_decode (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          hold,
  input  logic          fetch_en,
  input  logic [1:0]    fetch_byte,
  input  logic [7:0]    data_in,
  output rv_pkg::dec_t  dec,
  output rv_pkg::word_t imm,
  output logic          inst_ready
);
  import rv_pkg::*;

  inst_u inst;

  function automatic alu_op_e alu_map(input logic [2:0] f3, input logic alt,
                                      input logic is_reg);
    alu_op_e op;
    case (f3)
      3'b000:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;  // addi has no sub
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  function automatic mem_size_e size_map(input logic [1:0] f3_lo);
    case (f3_lo)
      2'b00:   return MEM_BYTE;
      2'b01:   return MEM_HALF;
      default: return MEM_WORD;
    endcase
  endfunction

  // little-endian byte capture
  always_ff @(posedge clk) begin
    if (fetch_en && !hold) begin
      inst.raw[{fetch_byte, 3'b000} +: 8] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      inst_ready <= 1'b0;
    end else if (!hold) begin
      inst_ready <= fetch_en && (fetch_byte == 2'd3);
    end
  end

  always_comb begin
    dec           = '0;
    dec.op_class  = CLS_NOP;               // system, fence and unknown
    dec.alu_op    = ALU_ADD;
    dec.mem_size  = MEM_WORD;
    dec.funct3    = inst.r.funct3;
    imm           = '0;
    case (inst.r.opcode)
      `RV_OPC_LUI, `RV_OPC_AUIPC: begin
        dec.op_class = CLS_ALU;
        dec.alu_op   = (inst.u.opcode == `RV_OPC_LUI) ? ALU_PASS_B : ALU_ADD;
        dec.use_pc   = (inst.u.opcode == `RV_OPC_AUIPC);
        dec.use_imm  = 1'b1;
        dec.rd       = inst.u.rd;
        imm          = {inst.u.imm, 12'b0};
      end
      `RV_OPC_JAL: begin
        dec.op_class = CLS_JAL;
        dec.rd       = inst.j.rd;
        imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12, inst.j.imm11,
               inst.j.imm10_1, 1'b0};
      end
      `RV_OPC_JALR, `RV_OPC_LOAD, `RV_OPC_OPIMM: begin
        dec.op_class = (inst.i.opcode == `RV_OPC_JALR) ? CLS_JALR :
                       (inst.i.opcode == `RV_OPC_LOAD) ? CLS_LOAD : CLS_ALU;
        dec.alu_op        = alu_map(inst.i.funct3, inst.i.imm[10], 1'b0);
        dec.use_imm       = 1'b1;
        dec.rd            = inst.i.rd;
        dec.rs1           = inst.i.rs1;
        dec.mem_size      = size_map(inst.i.funct3[1:0]);
        dec.load_unsigned = inst.i.funct3[2];  // lbu, lhu
        imm               = {{20{inst.i.imm[11]}}, inst.i.imm};
      end
      `RV_OPC_STORE: begin
        dec.op_class = CLS_STORE;
        dec.rs1      = inst.s.rs1;
        dec.rs2      = inst.s.rs2;
        dec.mem_size = size_map(inst.s.funct3[1:0]);
        imm          = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      end
      `RV_OPC_BRANCH: begin
        dec.op_class = CLS_BRANCH;
        dec.rs1      = inst.b.rs1;
        dec.rs2      = inst.b.rs2;
        imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
               inst.b.imm4_1, 1'b0};
      end
      `RV_OPC_OP: begin
        dec.op_class = CLS_ALU;
        dec.alu_op   = alu_map(inst.r.funct3, inst.r.funct7[5], 1'b1);
        dec.rd       = inst.r.rd;
        dec.rs1      = inst.r.rs1;
        dec.rs2      = inst.r.rs2;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: src/rv_control.sv
//**************************************************************************
// core sequencer: fetch, execute and memory phases, pc and bus address
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none
`include "rv_params.svh"

module rv_control (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  hold,
  input  logic                  inst_ready,
  input  rv_pkg::dec_t          dec,
  input  logic                  branch_taken,
  input  rv_pkg::word_t         target,
  input  rv_pkg::word_t         eff_addr,
  input  logic                  mem_busy,
  output logic                  fetch_en,
  output logic [1:0]            fetch_byte,
  output logic                  lsu_start,
  output logic                  wb_en,
  output logic [1:0]            wb_sel,
  output rv_pkg::word_t         pc,
  output logic [`RV_ADDR_W-1:0] address
);
  import rv_pkg::*;

  typedef enum logic [1:0] {PH_FETCH, PH_EXEC, PH_MEM} phase_e;

  phase_e phase;
  word_t  mem_addr;                      // running load/store address
  word_t  next_pc;
  word_t  fetch_addr;
  logic   exec_go;
  logic   is_mem;
  logic   is_jump;
  logic   mem_last;

  always_comb begin
    exec_go  = (phase == PH_EXEC) && inst_ready && !hold;
    mem_last = (phase == PH_MEM) && !mem_busy && !hold;
    is_mem   = (dec.op_class == CLS_LOAD) || (dec.op_class == CLS_STORE);
    is_jump  = (dec.op_class == CLS_JAL) || (dec.op_class == CLS_JALR);
    next_pc  = (branch_taken || is_jump) ? target : pc + 32'd4;

    fetch_en  = (phase == PH_FETCH);
    lsu_start = exec_go && is_mem;

    wb_en  = 1'b0;
    wb_sel = `RV_WB_ALU;
    if (exec_go && dec.op_class == CLS_ALU) begin
      wb_en = 1'b1;
    end else if (exec_go && is_jump) begin
      wb_en  = 1'b1;
      wb_sel = `RV_WB_LINK;                // rd gets pc+4
    end else if (mem_last && dec.op_class == CLS_LOAD) begin
      wb_en  = 1'b1;
      wb_sel = `RV_WB_LOAD;
    end
    if (dec.rd == '0) begin
      wb_en = 1'b0;                        // x0 never written
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase      <= PH_FETCH;
      fetch_byte <= 2'd0;
      pc         <= `RV_START_ADDR;
    end else if (!hold) begin
      case (phase)
        PH_FETCH: begin
          fetch_byte <= fetch_byte + 2'd1;  // wraps back to byte 0
          if (fetch_byte == 2'd3) begin
            phase <= PH_EXEC;
          end
        end
        PH_EXEC: begin
          if (inst_ready) begin
            if (is_mem) begin
              phase <= PH_MEM;
            end else begin
              pc    <= next_pc;
              phase <= PH_FETCH;
            end
          end
        end
        PH_MEM: begin
          if (!mem_busy) begin
            pc    <= pc + 32'd4;
            phase <= PH_FETCH;
          end
        end
        default: phase <= PH_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (exec_go) begin
      mem_addr <= eff_addr;
    end else if (phase == PH_MEM && !hold) begin
      mem_addr <= mem_addr + 32'd1;
    end
  end

  assign fetch_addr = pc + word_t'(fetch_byte);
  assign address    = (phase == PH_MEM) ? mem_addr[`RV_ADDR_W-1:0]
                                        : fetch_addr[`RV_ADDR_W-1:0];

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
//**************************************************************************
// rv32i core types: instruction formats, decoded operation and enums
//**************************************************************************
`default_nettype none
`include "rv_params.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0]          reg_idx_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;                  // imm[11:5]
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;                  // imm[4:0]
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;                    // imm[31:12]
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
    word_t  raw;
  } inst_u;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_ALU, CLS_BRANCH, CLS_JAL, CLS_JALR, CLS_LOAD, CLS_STORE, CLS_NOP
  } op_class_e;

  typedef enum logic [1:0] {
    MEM_BYTE, MEM_HALF, MEM_WORD
  } mem_size_e;

  typedef struct packed {
    op_class_e  op_class;
    alu_op_e    alu_op;
    logic [2:0] funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    mem_size_e  mem_size;
    logic       load_unsigned;
    logic       use_imm;                 // operand b from immediate
    logic       use_pc;                  // operand a from pc (auipc)
  } dec_t;

endpackage

`default_nettype wire

// File: src/rv_params.svh
//**************************************************************************
// rv32i core constants: bus widths, register count, reset pc and opcodes
//**************************************************************************
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_XLEN        32
`define RV_ADDR_W      16
`define RV_NREGS       32
`define RV_START_ADDR  32'h0000_0000

`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_OPIMM   7'b0010011
`define RV_OPC_OP      7'b0110011

// writeback source select
`define RV_WB_ALU      2'd0
`define RV_WB_LOAD     2'd1
`define RV_WB_LINK     2'd2

`endif
